// File: hdl/issue_cfg_pkg.sv
// sizes for a single-issue rv32 integer core; only two commit ports and 32 registers are supported
`default_nettype none

package issue_cfg_pkg;

  // ------------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------------

  // integer data width, rv32 only
  localparam int unsigned xlen = 32;

  // ------------------------------------------------------------------
  // register file
  // ------------------------------------------------------------------

  // architectural integer registers, x0 included
  localparam int unsigned nr_regs = 32;

  // address bits to select one of nr_regs
  localparam int unsigned reg_addr_w = 5;

  // ------------------------------------------------------------------
  // scoreboard and commit
  // ------------------------------------------------------------------

  // write ports from the commit stage into the register file
  localparam int unsigned nr_commit_ports = 2;

  // scoreboard transaction id, enough for 8 in-flight entries
  localparam int unsigned trans_id_w = 3;

endpackage : issue_cfg_pkg

`default_nettype wire

// File: hdl/issue_types_pkg.sv
// issue-stage types; fu_op_t is carried opaquely and its encoding is owned by the decoder
`default_nettype none

package issue_types_pkg;

  import issue_cfg_pkg::*;

  typedef logic [xlen-1:0]       xlen_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;
  typedef logic [trans_id_w-1:0] trans_id_t;

  // target unit of an entry, fu_none means the entry needs no unit
  typedef enum logic [2:0] {
    fu_none      = 3'd0,
    fu_alu       = 3'd1,
    fu_ctrl_flow = 3'd2,
    fu_mult      = 3'd3,
    fu_load      = 3'd4,
    fu_store     = 3'd5,
    fu_csr       = 3'd6
  } fu_t;

  // operation code, only passed through here
  typedef logic [6:0] fu_op_t;

  // ------------------------------------------------------------------
  // scoreboard side
  // ------------------------------------------------------------------

  typedef struct packed {
    xlen_t     pc;
    trans_id_t trans_id;
    fu_t       fu;
    fu_op_t    op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    // holds the immediate while the entry waits for issue
    xlen_t     result;
    logic      use_imm;
    logic      use_zimm;
    logic      use_pc;
    logic      ex_valid;
    logic      is_compressed;
  } sb_entry_t;

  // per register, the unit whose in-flight result will write it
  typedef fu_t [nr_regs-1:0] clobber_tbl_t;

  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    xlen_t     wdata;
  } commit_wb_t;

  typedef commit_wb_t [nr_commit_ports-1:0] commit_vec_t;

  // ------------------------------------------------------------------
  // execute side
  // ------------------------------------------------------------------

  typedef struct packed {
    xlen_t operand_a;
    xlen_t operand_b;
    xlen_t imm;
  } operands_t;

  typedef struct packed {
    fu_t       fu;
    fu_op_t    operation;
    xlen_t     operand_a;
    xlen_t     operand_b;
    xlen_t     imm;
    trans_id_t trans_id;
  } fu_data_t;

  // one-hot per cycle, at most one flag set
  typedef struct packed {
    logic alu;
    logic branch;
    logic mult;
    logic lsu;
    logic csr;
  } unit_valid_t;

endpackage : issue_types_pkg

`default_nettype wire

// File: hdl/issue_hazard_ctrl.sv
// purely combinational issue decision; rs1_i/rs2_i valid flags must arrive in the same cycle
`default_nettype none
`timescale 1ns/10ps

module issue_hazard_ctrl
  import issue_cfg_pkg::*;
  import issue_types_pkg::*;
(
  input  sb_entry_t    issue_instr_i,
  input  logic         issue_valid_i,
  input  logic         stall_i,
  input  logic         flu_ready_i,
  input  logic         lsu_ready_i,
  input  logic         rs1_valid_i,
  input  logic         rs2_valid_i,
  input  clobber_tbl_t rd_clobber_i,
  input  commit_vec_t  commit_i,
  // a multiply was dispatched last cycle
  input  logic         mult_issued_i,
  output logic         issue_ack_o,
  output logic         dispatch_o,
  output logic         forward_rs1_o,
  output logic         forward_rs2_o,
  output logic         stall_issue_o
);

  logic fu_busy;
  logic rd_free;
  logic rd_committed;

  // ------------------------------------------------------------------
  // unit busy
  // ------------------------------------------------------------------

  always_comb begin
    case (issue_instr_i.fu)
      fu_alu, fu_ctrl_flow, fu_mult, fu_csr: fu_busy = ~flu_ready_i;
      fu_load, fu_store:                     fu_busy = ~lsu_ready_i;
      default:                               fu_busy = 1'b0;
    endcase
  end

  // ------------------------------------------------------------------
  // operand availability
  // ------------------------------------------------------------------

  always_comb begin
    stall_issue_o = stall_i;
    forward_rs1_o = 1'b0;
    forward_rs2_o = 1'b0;
    // zimm lives in the rs1 field, so nothing to wait on then
    if (!issue_instr_i.use_zimm && rd_clobber_i[issue_instr_i.rs1] != fu_none) begin
      // csr results only ever reach us through the register file
      if (rs1_valid_i && rd_clobber_i[issue_instr_i.rs1] != fu_csr) begin
        forward_rs1_o = 1'b1;
      end else begin
        stall_issue_o = 1'b1;
      end
    end
    if (rd_clobber_i[issue_instr_i.rs2] != fu_none) begin
      if (rs2_valid_i && rd_clobber_i[issue_instr_i.rs2] != fu_csr) begin
        forward_rs2_o = 1'b1;
      end else begin
        stall_issue_o = 1'b1;
      end
    end
  end

  // ------------------------------------------------------------------
  // write after write and acknowledge
  // ------------------------------------------------------------------

  assign rd_free = (rd_clobber_i[issue_instr_i.rd] == fu_none);

  // older writer of rd retires right now, so the slot frees this edge
  always_comb begin
    rd_committed = 1'b0;
    for (int i = 0; i < nr_commit_ports; i++) begin
      if (commit_i[i].we && commit_i[i].waddr == issue_instr_i.rd) begin
        rd_committed = 1'b1;
      end
    end
  end

  always_comb begin
    issue_ack_o = 1'b0;
    if (issue_valid_i) begin
      if (!stall_issue_o && !fu_busy && (rd_free || rd_committed)) begin
        issue_ack_o = 1'b1;
      end
      // exceptions and unit-less entries just drain
      if (issue_instr_i.ex_valid || issue_instr_i.fu == fu_none) begin
        issue_ack_o = 1'b1;
      end
    end
    // mult result shares the fixed-latency writeback bus next cycle
    if (mult_issued_i &&
        issue_instr_i.fu inside {fu_alu, fu_ctrl_flow, fu_csr}) begin
      issue_ack_o = 1'b0;
    end
  end

  assign dispatch_o = issue_valid_i && issue_ack_o && !issue_instr_i.ex_valid;

endmodule : issue_hazard_ctrl

`default_nettype wire

// File: hdl/operand_select.sv
// combinational operand mux; zimm beats pc beats forwarding beats register file for operand a
`default_nettype none
`timescale 1ns/10ps

module operand_select
  import issue_cfg_pkg::*;
  import issue_types_pkg::*;
(
  input  sb_entry_t issue_instr_i,
  // register file read data
  input  xlen_t     rf_rdata_a_i,
  input  xlen_t     rf_rdata_b_i,
  // scoreboard forwarding data
  input  xlen_t     rs1_i,
  input  xlen_t     rs2_i,
  input  logic      forward_rs1_i,
  input  logic      forward_rs2_i,
  output operands_t operands_o
);

  logic use_imm_b;

  // stores and branches keep rs2 in operand b, imm goes separately
  assign use_imm_b = issue_instr_i.use_imm &&
                     issue_instr_i.fu != fu_store &&
                     issue_instr_i.fu != fu_ctrl_flow;

  always_comb begin
    // operand a
    if (issue_instr_i.use_zimm) begin
      // csr immediate form, zero extended
      operands_o.operand_a = {{(xlen - reg_addr_w){1'b0}}, issue_instr_i.rs1};
    end else if (issue_instr_i.use_pc) begin
      operands_o.operand_a = issue_instr_i.pc;
    end else if (forward_rs1_i) begin
      operands_o.operand_a = rs1_i;
    end else begin
      operands_o.operand_a = rf_rdata_a_i;
    end
    // operand b
    if (use_imm_b) begin
      operands_o.operand_b = issue_instr_i.result;
    end else if (forward_rs2_i) begin
      operands_o.operand_b = rs2_i;
    end else begin
      operands_o.operand_b = rf_rdata_b_i;
    end
    operands_o.imm = issue_instr_i.result;
  end

endmodule : operand_select

`default_nettype wire

// File: hdl/int_regfile.sv
// flop-based integer register file; reads are combinational and see the value before this edge's writes
`default_nettype none
`timescale 1ns/10ps

module int_regfile
  import issue_cfg_pkg::*;
  import issue_types_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  reg_addr_t   raddr_a_i,
  input  reg_addr_t   raddr_b_i,
  input  commit_vec_t commit_i,
  output xlen_t       rdata_a_o,
  output xlen_t       rdata_b_o
);

  // x0 has no storage
  xlen_t mem_q [1:nr_regs-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 1; r < nr_regs; r++) begin
        mem_q[r] <= '0;
      end
    end else begin
      // later ports overwrite earlier ones on an address clash
      for (int i = 0; i < nr_commit_ports; i++) begin
        if (commit_i[i].we && commit_i[i].waddr != '0) begin
          mem_q[commit_i[i].waddr] <= commit_i[i].wdata;
        end
      end
    end
  end

  // x0 reads as zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : mem_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : mem_q[raddr_b_i];

endmodule : int_regfile

`default_nettype wire

// File: hdl/dispatch_reg.sv
// issue to execute register; payload follows the entry every cycle, only unit_valid_o marks it live
`default_nettype none
`timescale 1ns/10ps

module dispatch_reg
  import issue_cfg_pkg::*;
  import issue_types_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_i,
  // taken entry without exception
  input  logic        dispatch_i,
  input  sb_entry_t   issue_instr_i,
  input  operands_t   operands_i,
  output fu_data_t    fu_data_o,
  output xlen_t       pc_o,
  output logic        is_compressed_o,
  output unit_valid_t unit_valid_o
);

  unit_valid_t unit_valid_d;

  // ------------------------------------------------------------------
  // per-unit valid
  // ------------------------------------------------------------------

  always_comb begin
    unit_valid_d = '0;
    // flush wins over a dispatch in the same cycle
    if (dispatch_i && !flush_i) begin
      case (issue_instr_i.fu)
        fu_alu:            unit_valid_d.alu    = 1'b1;
        fu_ctrl_flow:      unit_valid_d.branch = 1'b1;
        fu_mult:           unit_valid_d.mult   = 1'b1;
        fu_load, fu_store: unit_valid_d.lsu    = 1'b1;
        fu_csr:            unit_valid_d.csr    = 1'b1;
        // fu_none needs no unit
        default:           unit_valid_d        = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      unit_valid_o <= '0;
    end else begin
      unit_valid_o <= unit_valid_d;
    end
  end

  // ------------------------------------------------------------------
  // operand bundle
  // ------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fu_data_o       <= '{fu: fu_none, operation: '0, operand_a: '0,
                           operand_b: '0, imm: '0, trans_id: '0};
      pc_o            <= '0;
      is_compressed_o <= 1'b0;
    end else begin
      fu_data_o.fu        <= issue_instr_i.fu;
      fu_data_o.operation <= issue_instr_i.op;
      fu_data_o.operand_a <= operands_i.operand_a;
      fu_data_o.operand_b <= operands_i.operand_b;
      fu_data_o.imm       <= operands_i.imm;
      fu_data_o.trans_id  <= issue_instr_i.trans_id;
      pc_o                <= issue_instr_i.pc;
      is_compressed_o     <= issue_instr_i.is_compressed;
    end
  end

endmodule : dispatch_reg

`default_nettype wire

// File: hdl/issue_read_operands.sv
// issue and operand-read stage top; issue_ack_o is combinational from the entry and scoreboard inputs
`default_nettype none
`timescale 1ns/10ps

module issue_read_operands
  import issue_cfg_pkg::*;
  import issue_types_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         flush_i,
  input  logic         stall_i,
  // issue handshake with the scoreboard
  input  sb_entry_t    issue_instr_i,
  input  logic         issue_valid_i,
  output logic         issue_ack_o,
  // forwarding lookup
  output reg_addr_t    rs1_o,
  output reg_addr_t    rs2_o,
  input  xlen_t        rs1_i,
  input  xlen_t        rs2_i,
  input  logic         rs1_valid_i,
  input  logic         rs2_valid_i,
  input  clobber_tbl_t rd_clobber_i,
  // unit readiness
  input  logic         flu_ready_i,
  input  logic         lsu_ready_i,
  input  commit_vec_t  commit_i,
  // execute side
  output fu_data_t     fu_data_o,
  output xlen_t        pc_o,
  output logic         is_compressed_o,
  output unit_valid_t  unit_valid_o,
  output logic         stall_issue_o
);

  logic      dispatch;
  logic      forward_rs1;
  logic      forward_rs2;
  xlen_t     rf_rdata_a;
  xlen_t     rf_rdata_b;
  operands_t operands;

  // scoreboard is polled with the entry's own sources
  assign rs1_o = issue_instr_i.rs1;
  assign rs2_o = issue_instr_i.rs2;

  issue_hazard_ctrl i_hazard_ctrl (
    .issue_instr_i (issue_instr_i),
    .issue_valid_i (issue_valid_i),
    .stall_i       (stall_i),
    .flu_ready_i   (flu_ready_i),
    .lsu_ready_i   (lsu_ready_i),
    .rs1_valid_i   (rs1_valid_i),
    .rs2_valid_i   (rs2_valid_i),
    .rd_clobber_i  (rd_clobber_i),
    .commit_i      (commit_i),
    .mult_issued_i (unit_valid_o.mult),
    .issue_ack_o   (issue_ack_o),
    .dispatch_o    (dispatch),
    .forward_rs1_o (forward_rs1),
    .forward_rs2_o (forward_rs2),
    .stall_issue_o (stall_issue_o)
  );

  int_regfile i_int_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (issue_instr_i.rs1),
    .raddr_b_i (issue_instr_i.rs2),
    .commit_i  (commit_i),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b)
  );

  operand_select i_operand_select (
    .issue_instr_i (issue_instr_i),
    .rf_rdata_a_i  (rf_rdata_a),
    .rf_rdata_b_i  (rf_rdata_b),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .forward_rs1_i (forward_rs1),
    .forward_rs2_i (forward_rs2),
    .operands_o    (operands)
  );

  dispatch_reg i_dispatch_reg (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .dispatch_i      (dispatch),
    .issue_instr_i   (issue_instr_i),
    .operands_i      (operands),
    .fu_data_o       (fu_data_o),
    .pc_o            (pc_o),
    .is_compressed_o (is_compressed_o),
    .unit_valid_o    (unit_valid_o)
  );

endmodule : issue_read_operands

`default_nettype wire

// File: dv/issue_checker.sv
// bound to issue_read_operands; sampled on the rising edge, off in reset, failed stays high after a hit
`default_nettype none
`timescale 1ns/10ps

module issue_checker
  import issue_cfg_pkg::*;
  import issue_types_pkg::*;
(
  input logic         clk_i,
  input logic         rst_ni,
  input logic         flush_i,
  input logic         stall_i,
  input sb_entry_t    issue_instr_i,
  input logic         issue_valid_i,
  input logic         issue_ack_o,
  input logic         rs1_valid_i,
  input clobber_tbl_t rd_clobber_i,
  input logic         flu_ready_i,
  input logic         lsu_ready_i,
  input commit_vec_t  commit_i,
  input unit_valid_t  unit_valid_o,
  input logic         stall_issue_o
);

  // read by the testbench
  logic failed = 1'b0;

  logic live;
  logic taken;
  logic rs1_blocked;
  logic rd_blocked;
  logic unit_busy;
  fu_t  fu_q;

  // load and store share the lsu flag, ctrl_flow maps to branch
  function automatic unit_valid_t flag_for(input fu_t fu);
    unit_valid_t f;
    f = '0;
    case (fu)
      fu_alu:            f.alu    = 1'b1;
      fu_ctrl_flow:      f.branch = 1'b1;
      fu_mult:           f.mult   = 1'b1;
      fu_load, fu_store: f.lsu    = 1'b1;
      fu_csr:            f.csr    = 1'b1;
      default:           f        = '0;
    endcase
    return f;
  endfunction

  // ------------------------------------------------------------------
  // hazard conditions seen from outside
  // ------------------------------------------------------------------

  always_comb begin
    // entry that has to pass every hazard check
    live  = issue_valid_i && !issue_instr_i.ex_valid && issue_instr_i.fu != fu_none;
    taken = issue_valid_i && issue_ack_o;
    // zimm form has no rs1 to wait on
    rs1_blocked = !issue_instr_i.use_zimm &&
                  rd_clobber_i[issue_instr_i.rs1] != fu_none &&
                  (rd_clobber_i[issue_instr_i.rs1] == fu_csr || !rs1_valid_i);
    rd_blocked = rd_clobber_i[issue_instr_i.rd] != fu_none;
    // a commit of rd in this cycle frees it
    for (int i = 0; i < nr_commit_ports; i++) begin
      if (commit_i[i].we && commit_i[i].waddr == issue_instr_i.rd) begin
        rd_blocked = 1'b0;
      end
    end
    unit_busy = (issue_instr_i.fu inside {fu_load, fu_store}) ? !lsu_ready_i : !flu_ready_i;
  end

  // unit of the entry seen at the last edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fu_q <= fu_none;
    end else begin
      fu_q <= issue_instr_i.fu;
    end
  end

  // ------------------------------------------------------------------
  // assertions
  // ------------------------------------------------------------------

  // csr clobber or missing forward keeps the entry waiting
  rs1_wait_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    live && rs1_blocked |-> !issue_ack_o)
    else begin
      failed = 1'b1;
      $error("ack given while rs1 was not available");
    end

  // write after write
  rd_wait_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    live && rd_blocked |-> !issue_ack_o)
    else begin
      failed = 1'b1;
      $error("ack given while rd still had an older writer");
    end

  busy_wait_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    live && unit_busy |-> !issue_ack_o)
    else begin
      failed = 1'b1;
      $error("ack given while the target unit was not ready");
    end

  // shared fixed-latency bus after a multiply
  mult_wait_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    unit_valid_o.mult && issue_instr_i.fu inside {fu_alu, fu_ctrl_flow, fu_csr}
    |-> !issue_ack_o)
    else begin
      failed = 1'b1;
      $error("ack given in the cycle after a multiply");
    end

  // exactly the flag of the unit, one cycle later
  flag_set_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    taken && live && !flush_i |=> unit_valid_o == flag_for(fu_q))
    else begin
      failed = 1'b1;
      $error("wrong unit flags after a dispatch");
    end

  // no flag without a live, unflushed dispatch one cycle earlier
  flag_none_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(taken && live && !flush_i) |=> unit_valid_o == '0)
    else begin
      failed = 1'b1;
      $error("unit flag raised without a dispatch one cycle earlier");
    end

  // outer stall or a blocked rs1 both hold the stage
  stall_follow_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    stall_i || rs1_blocked |-> stall_issue_o)
    else begin
      failed = 1'b1;
      $error("stall_issue_o low while the stage had to stall");
    end

endmodule : issue_checker

bind issue_read_operands issue_checker i_issue_checker (.*);

`default_nettype wire

// File: dv/issue_tb.sv
// directed and random issue tests; protocol rules sit in the bound checker, operand data is compared here
`default_nettype none
`timescale 1ns/10ps

module issue_tb
  import issue_cfg_pkg::*;
  import issue_types_pkg::*;
();

  localparam int clk_period = 8;
  // entries and commit cycles the run plans, sets the watchdog
  localparam int n_planned  = 64;
  localparam int n_random   = 24;
  // cycles an entry may wait for its ack
  localparam int ack_limit  = 8;

  logic         clk_i = 1'b0;
  logic         rst_ni;
  logic         flush_i;
  logic         stall_i;
  sb_entry_t    issue_instr_i;
  logic         issue_valid_i;
  logic         issue_ack_o;
  reg_addr_t    rs1_o;
  reg_addr_t    rs2_o;
  xlen_t        rs1_i;
  xlen_t        rs2_i;
  logic         rs1_valid_i;
  logic         rs2_valid_i;
  clobber_tbl_t rd_clobber_i;
  logic         flu_ready_i;
  logic         lsu_ready_i;
  commit_vec_t  commit_i;
  fu_data_t     fu_data_o;
  xlen_t        pc_o;
  logic         is_compressed_o;
  unit_valid_t  unit_valid_o;
  logic         stall_issue_o;

  int           seed = 32'h0c16_912f;
  // architectural view, fed from the commits driven below
  xlen_t        shadow [nr_regs];
  logic         checker_failed;
  sb_entry_t    e;

  always #(clk_period / 2) clk_i = ~clk_i;

  issue_read_operands i_issue_read_operands (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .stall_i         (stall_i),
    .issue_instr_i   (issue_instr_i),
    .issue_valid_i   (issue_valid_i),
    .issue_ack_o     (issue_ack_o),
    .rs1_o           (rs1_o),
    .rs2_o           (rs2_o),
    .rs1_i           (rs1_i),
    .rs2_i           (rs2_i),
    .rs1_valid_i     (rs1_valid_i),
    .rs2_valid_i     (rs2_valid_i),
    .rd_clobber_i    (rd_clobber_i),
    .flu_ready_i     (flu_ready_i),
    .lsu_ready_i     (lsu_ready_i),
    .commit_i        (commit_i),
    .fu_data_o       (fu_data_o),
    .pc_o            (pc_o),
    .is_compressed_o (is_compressed_o),
    .unit_valid_o    (unit_valid_o),
    .stall_issue_o   (stall_issue_o)
  );

  assign checker_failed = i_issue_read_operands.i_issue_checker.failed;

  // x0 is never written, higher port wins on a clash
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int r = 0; r < nr_regs; r++) begin
        shadow[r] <= '0;
      end
    end else begin
      for (int p = 0; p < nr_commit_ports; p++) begin
        if (commit_i[p].we && commit_i[p].waddr != '0) begin
          shadow[commit_i[p].waddr] <= commit_i[p].wdata;
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------

  task automatic end_failed(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
    assert (got === exp) else begin
      end_failed($sformatf("ERROR time=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic set_commit(input bit port, input reg_addr_t addr, input xlen_t data);
    commit_i[port].we    = 1'b1;
    commit_i[port].waddr = addr;
    commit_i[port].wdata = data;
  endtask

  function automatic sb_entry_t make_entry(input fu_t fu, input reg_addr_t rs1,
                                           input reg_addr_t rs2, input reg_addr_t rd);
    sb_entry_t n;
    n               = '0;
    n.pc            = $random(seed);
    n.trans_id      = trans_id_t'($random(seed));
    n.op            = fu_op_t'($random(seed));
    n.result        = $random(seed);
    n.is_compressed = 1'($random(seed));
    n.fu            = fu;
    n.rs1           = rs1;
    n.rs2           = rs2;
    n.rd            = rd;
    return n;
  endfunction

  // operand a priority: zimm, pc, forwarded value, register
  function automatic xlen_t exp_a(input sb_entry_t n);
    if (n.use_zimm) return xlen_t'(n.rs1);
    if (n.use_pc) return n.pc;
    if (rd_clobber_i[n.rs1] != fu_none) return rs1_i;
    return shadow[n.rs1];
  endfunction

  // store and branch keep rs2 in operand b
  function automatic xlen_t exp_b(input sb_entry_t n);
    if (n.use_imm && n.fu != fu_store && n.fu != fu_ctrl_flow) return n.result;
    if (rd_clobber_i[n.rs2] != fu_none) return rs2_i;
    return shadow[n.rs2];
  endfunction

  task automatic release_entry();
    issue_valid_i = 1'b0;
    flush_i       = 1'b0;
    commit_i      = '0;
  endtask

  // called 1 ns after an edge, returns 1 ns after the taking edge
  task automatic send_entry(input sb_entry_t n, input bit check_data);
    int    waited;
    xlen_t ea;
    xlen_t eb;
    waited        = 0;
    issue_instr_i = n;
    issue_valid_i = 1'b1;
    @(negedge clk_i);
    while (!issue_ack_o) begin
      if (waited == ack_limit) begin
        end_failed("an entry was never acknowledged by the issue stage");
      end
      waited++;
      @(negedge clk_i);
    end
    // scoreboard lookup uses the entry's own sources
    check_word("rs1_o", xlen_t'(rs1_o), xlen_t'(n.rs1));
    check_word("rs2_o", xlen_t'(rs2_o), xlen_t'(n.rs2));
    // values before the edge, a same-cycle commit is not seen
    ea = exp_a(n);
    eb = exp_b(n);
    @(posedge clk_i);
    #1;
    if (check_data) begin
      check_word("fu_data_o.operand_a", fu_data_o.operand_a, ea);
      check_word("fu_data_o.operand_b", fu_data_o.operand_b, eb);
      check_word("fu_data_o.imm", fu_data_o.imm, n.result);
      check_word("fu_data_o.fu", xlen_t'(fu_data_o.fu), xlen_t'(n.fu));
      check_word("fu_data_o.operation", xlen_t'(fu_data_o.operation), xlen_t'(n.op));
      check_word("fu_data_o.trans_id", xlen_t'(fu_data_o.trans_id), xlen_t'(n.trans_id));
      check_word("pc_o", pc_o, n.pc);
      check_word("is_compressed_o", xlen_t'(is_compressed_o), xlen_t'(n.is_compressed));
    end
    release_entry();
  endtask

  task automatic expect_no_ack(input sb_entry_t n);
    issue_instr_i = n;
    issue_valid_i = 1'b1;
    @(negedge clk_i);
    check_word("issue_ack_o", xlen_t'(issue_ack_o), '0);
    @(posedge clk_i);
    #1;
    release_entry();
  endtask

  // ------------------------------------------------------------------
  // watchdog and checker monitor
  // ------------------------------------------------------------------

  initial begin
    #(n_planned * 20 * clk_period);
    end_failed("watchdog expired before the test reached a result");
  end

  always @(negedge clk_i) begin
    if (checker_failed) begin
      end_failed("a protocol assertion in the checker failed");
    end
  end

  // ------------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------------

  initial begin
    rst_ni        = 1'b0;
    flush_i       = 1'b0;
    stall_i       = 1'b0;
    issue_instr_i = '0;
    issue_valid_i = 1'b0;
    rs1_i         = '0;
    rs2_i         = '0;
    rs1_valid_i   = 1'b0;
    rs2_valid_i   = 1'b0;
    rd_clobber_i  = '0;
    flu_ready_i   = 1'b1;
    lsu_ready_i   = 1'b1;
    commit_i      = '0;
    e             = '0;
    repeat (5) @(posedge clk_i);
    #1;
    // reset state of the execute side
    check_word("unit_valid_o", xlen_t'(unit_valid_o), '0);
    check_word("fu_data_o.fu", xlen_t'(fu_data_o.fu), xlen_t'(fu_none));
    check_word("pc_o", pc_o, '0);
    rst_ni = 1'b1;

    // fill every register, x0 write attempt included
    for (int r = 0; r < nr_regs; r += 2) begin
      set_commit(1'b0, reg_addr_t'(r), $random(seed));
      set_commit(1'b1, reg_addr_t'(r + 1), $random(seed));
      @(posedge clk_i);
      #1;
      commit_i = '0;
    end

    // random alu reads with a commit in the same cycle now and then
    for (int k = 0; k < n_random; k++) begin
      e = make_entry(fu_alu, reg_addr_t'($random(seed)), reg_addr_t'($random(seed)),
                     reg_addr_t'($random(seed)));
      if (k % 6 == 0) begin
        e.rs1 = '0;
      end
      if ($random(seed) & 1) begin
        set_commit(1'b1, reg_addr_t'($random(seed)), $random(seed));
      end
      send_entry(e, 1'b1);
    end

    // forwarding of both sources
    rd_clobber_i[5] = fu_alu;
    rd_clobber_i[6] = fu_mult;
    rs1_valid_i     = 1'b1;
    rs2_valid_i     = 1'b1;
    rs1_i           = $random(seed);
    rs2_i           = $random(seed);
    send_entry(make_entry(fu_alu, 5, 6, 9), 1'b1);
    rd_clobber_i[6] = fu_none;
    // csr results are never forwarded
    rd_clobber_i[5] = fu_csr;
    expect_no_ack(make_entry(fu_alu, 5, 6, 9));
    rd_clobber_i[5] = fu_load;
    rs1_valid_i     = 1'b0;
    expect_no_ack(make_entry(fu_alu, 5, 6, 9));
    rd_clobber_i[5] = fu_none;

    // write after write, freed by a same-cycle commit
    rd_clobber_i[7] = fu_load;
    expect_no_ack(make_entry(fu_alu, 1, 2, 7));
    set_commit(1'b0, 7, $random(seed));
    send_entry(make_entry(fu_alu, 1, 2, 7), 1'b1);
    rd_clobber_i[7] = fu_none;

    // exception and unit-less entries drain without a flag
    e               = make_entry(fu_alu, 5, 6, 9);
    e.ex_valid      = 1'b1;
    rd_clobber_i[5] = fu_csr;
    send_entry(e, 1'b0);
    rd_clobber_i[5] = fu_none;
    send_entry(make_entry(fu_none, 3, 4, 9), 1'b0);
    flush_i = 1'b1;
    send_entry(make_entry(fu_alu, 3, 4, 9), 1'b0);

    // stall and unit back-pressure
    stall_i = 1'b1;
    expect_no_ack(make_entry(fu_alu, 3, 4, 9));
    stall_i     = 1'b0;
    lsu_ready_i = 1'b0;
    expect_no_ack(make_entry(fu_load, 3, 4, 9));
    expect_no_ack(make_entry(fu_store, 3, 4, 0));
    lsu_ready_i = 1'b1;
    flu_ready_i = 1'b0;
    expect_no_ack(make_entry(fu_alu, 3, 4, 9));
    expect_no_ack(make_entry(fu_ctrl_flow, 3, 4, 0));
    expect_no_ack(make_entry(fu_mult, 3, 4, 9));
    expect_no_ack(make_entry(fu_csr, 3, 4, 9));
    flu_ready_i = 1'b1;

    // the cycle after a multiply blocks alu, branch and csr
    send_entry(make_entry(fu_mult, 8, 9, 13), 1'b1);
    expect_no_ack(make_entry(fu_alu, 8, 9, 14));
    send_entry(make_entry(fu_mult, 8, 9, 13), 1'b1);
    expect_no_ack(make_entry(fu_csr, 8, 9, 14));
    send_entry(make_entry(fu_mult, 8, 9, 13), 1'b1);
    expect_no_ack(make_entry(fu_ctrl_flow, 8, 9, 0));
    send_entry(make_entry(fu_alu, 8, 9, 14), 1'b1);

    // operand choice
    e        = make_entry(fu_alu, 3, 4, 10);
    e.use_pc = 1'b1;
    send_entry(e, 1'b1);
    e                = make_entry(fu_csr, 21, 0, 11);
    e.use_zimm       = 1'b1;
    rd_clobber_i[21] = fu_csr;
    send_entry(e, 1'b1);
    rd_clobber_i[21] = fu_none;
    e         = make_entry(fu_alu, 3, 4, 12);
    e.use_imm = 1'b1;
    send_entry(e, 1'b1);
    e         = make_entry(fu_store, 3, 4, 0);
    e.use_imm = 1'b1;
    send_entry(e, 1'b1);
    e         = make_entry(fu_ctrl_flow, 3, 4, 0);
    e.use_imm = 1'b1;
    send_entry(e, 1'b1);

    repeat (2) @(posedge clk_i);
    if (checker_failed) begin
      end_failed("a protocol assertion in the checker failed");
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

endmodule : issue_tb

`default_nettype wire

// File: issue_stage.f
hdl/issue_cfg_pkg.sv
hdl/issue_types_pkg.sv
hdl/issue_hazard_ctrl.sv
hdl/operand_select.sv
hdl/int_regfile.sv
hdl/dispatch_reg.sv
hdl/issue_read_operands.sv
dv/issue_checker.sv
dv/issue_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the issue stage testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module issue_tb \
  -f issue_stage.f

# assertion errors keep running so the testbench can print its own verdict
out=$(./obj_dir/Vissue_tb +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Result: PASSED'; then
  exit 0
fi
exit 1
